// File: hdl/axi_lite_if.sv
`timescale 1ns/1ps
`default_nettype none

interface axi_read_if;
	import fabric_pkg::*;

	logic [addr_width-1:0] araddr;
	logic                  arvalid;
	logic                  arready;
	logic [data_width-1:0] rdata;
	resp_t                 rresp;
	logic                  rvalid;
	logic                  rready;

	modport requester (output araddr, arvalid, rready, input arready, rdata, rresp, rvalid);
	modport responder (input araddr, arvalid, rready, output arready, rdata, rresp, rvalid);
endinterface

interface axi_write_if;
	import fabric_pkg::*;

	logic [addr_width-1:0] awaddr;
	logic                  awvalid;
	logic                  awready;
	logic [data_width-1:0] wdata;
	logic                  wvalid;
	logic                  wready;
	resp_t                 bresp;
	logic                  bvalid;
	logic                  bready;

	modport requester (
		output awaddr, awvalid, wdata, wvalid, bready,
		input awready, wready, bresp, bvalid
	);
	modport responder (
		input awaddr, awvalid, wdata, wvalid, bready,
		output awready, wready, bresp, bvalid
	);
endinterface

`default_nettype wire

// File: hdl/clint.sv
`timescale 1ns/1ps
`default_nettype none

module clint (
	input wire clock,
	input wire reset,
	axi_read_if.responder rd
);
	import fabric_pkg::*;

	logic [63:0] mtime;
	logic [addr_width-1:0] offset;

	assign offset = rd.araddr - clint_base;
	assign rd.arready = !rd.rvalid;

	always_ff @(posedge clock) begin
		if (reset) begin
			mtime <= '0;
			rd.rvalid <= 1'b0;
		end else begin
			mtime <= mtime + 64'd1; // free running with no compare logic
			if (rd.arvalid && rd.arready) rd.rvalid <= 1'b1;
			else if (rd.rready) rd.rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (rd.arvalid && rd.arready) begin
			if (offset == mtime_lo_offset) begin
				rd.rdata <= mtime[31:0];
				rd.rresp <= okay;
			end else if (offset == mtime_hi_offset) begin
				rd.rdata <= mtime[63:32];
				rd.rresp <= okay;
			end else begin
				rd.rdata <= '0;
				rd.rresp <= slverr; // no other registers in the window
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/fabric_pkg.sv
`default_nettype none

package fabric_pkg;

	localparam int addr_width = 32;
	localparam int data_width = 32;

	// cacheable regions with inclusive limits
	localparam logic [addr_width-1:0] flash_base  = 32'h3000_0000;
	localparam logic [addr_width-1:0] flash_limit = 32'h3fff_ffff;
	localparam logic [addr_width-1:0] psram_base  = 32'h8000_0000;
	localparam logic [addr_width-1:0] psram_limit = 32'h9fff_ffff;
	localparam logic [addr_width-1:0] sdram_base  = 32'ha000_0000;
	localparam logic [addr_width-1:0] sdram_limit = 32'hbfff_ffff;

	localparam logic [addr_width-1:0] clint_base  = 32'h0200_0000;
	localparam logic [addr_width-1:0] clint_limit = 32'h0200_ffff;

	localparam logic [addr_width-1:0] mtime_lo_offset = 32'h0000_0000;
	localparam logic [addr_width-1:0] mtime_hi_offset = 32'h0000_0004;

	localparam int icache_lines      = 16;
	localparam int icache_index_bits = $clog2(icache_lines);
	localparam int icache_tag_bits   = addr_width - icache_index_bits - 2; // word aligned lines

	typedef enum logic [1:0] {
		okay   = 2'd0,
		exokay = 2'd1,
		slverr = 2'd2,
		decerr = 2'd3 // also reported by the cache on a miss
	} resp_t;

	typedef enum logic [2:0] {
		idle,
		ifu_cache_lookup,
		ifu_mem_read,
		cache_fill,
		ifu_reply,
		lsu_read,
		lsu_reply
	} xbar_state_t;

endpackage

`default_nettype wire

// File: hdl/fetch_fabric.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_fabric (
	input wire clock,
	input wire reset,

	input wire [fabric_pkg::addr_width-1:0] ifu_araddr,
	input wire ifu_arvalid,
	output wire ifu_arready,
	output wire [fabric_pkg::data_width-1:0] ifu_rdata,
	output wire fabric_pkg::resp_t ifu_rresp,
	output wire ifu_rvalid,
	input wire ifu_rready,

	input wire [fabric_pkg::addr_width-1:0] lsu_araddr,
	input wire lsu_arvalid,
	output wire lsu_arready,
	output wire [fabric_pkg::data_width-1:0] lsu_rdata,
	output wire fabric_pkg::resp_t lsu_rresp,
	output wire lsu_rvalid,
	input wire lsu_rready,

	output wire [fabric_pkg::addr_width-1:0] mem_araddr,
	output wire mem_arvalid,
	input wire mem_arready,
	input wire [fabric_pkg::data_width-1:0] mem_rdata,
	input wire fabric_pkg::resp_t mem_rresp,
	input wire mem_rvalid,
	output wire mem_rready
);

	axi_read_if cache_rd_bus ();
	axi_write_if cache_wr_bus ();
	axi_read_if clint_rd_bus ();

	read_xbar u_xbar (
		.clock(clock),
		.reset(reset),
		.ifu_araddr(ifu_araddr),
		.ifu_arvalid(ifu_arvalid),
		.ifu_arready(ifu_arready),
		.ifu_rdata(ifu_rdata),
		.ifu_rresp(ifu_rresp),
		.ifu_rvalid(ifu_rvalid),
		.ifu_rready(ifu_rready),
		.lsu_araddr(lsu_araddr),
		.lsu_arvalid(lsu_arvalid),
		.lsu_arready(lsu_arready),
		.lsu_rdata(lsu_rdata),
		.lsu_rresp(lsu_rresp),
		.lsu_rvalid(lsu_rvalid),
		.lsu_rready(lsu_rready),
		.mem_araddr(mem_araddr),
		.mem_arvalid(mem_arvalid),
		.mem_arready(mem_arready),
		.mem_rdata(mem_rdata),
		.mem_rresp(mem_rresp),
		.mem_rvalid(mem_rvalid),
		.mem_rready(mem_rready),
		.cache_rd(cache_rd_bus.requester),
		.cache_wr(cache_wr_bus.requester),
		.clint_rd(clint_rd_bus.requester)
	);

	icache u_icache (
		.clock(clock),
		.reset(reset),
		.rd(cache_rd_bus.responder),
		.wr(cache_wr_bus.responder)
	);

	clint u_clint (
		.clock(clock),
		.reset(reset),
		.rd(clint_rd_bus.responder)
	);

endmodule

`default_nettype wire

// File: hdl/icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache (
	input wire clock,
	input wire reset,
	axi_read_if.responder rd,
	axi_write_if.responder wr
);
	import fabric_pkg::*;

	logic [icache_lines-1:0] line_valid;
	logic [icache_tag_bits-1:0] line_tag [icache_lines];
	logic [data_width-1:0] line_data [icache_lines];
	logic [icache_index_bits-1:0] rd_index;
	logic [icache_tag_bits-1:0] rd_tag;
	logic [icache_index_bits-1:0] wr_index;
	logic rd_hit;
	logic fill;

	assign rd_index = rd.araddr[icache_index_bits+1:2];
	assign rd_tag = rd.araddr[addr_width-1:icache_index_bits+2];
	assign rd_hit = line_valid[rd_index] && (line_tag[rd_index] == rd_tag);
	assign wr_index = wr.awaddr[icache_index_bits+1:2];

	assign rd.arready = !rd.rvalid; // one lookup in flight

	// address and data are always taken together
	assign fill = wr.awvalid && wr.wvalid && !wr.bvalid;
	assign wr.awready = fill;
	assign wr.wready = fill;

	always_ff @(posedge clock) begin
		if (reset) begin
			line_valid <= '0;
			rd.rvalid <= 1'b0;
			wr.bvalid <= 1'b0;
		end else begin
			if (rd.arvalid && rd.arready) rd.rvalid <= 1'b1;
			else if (rd.rready) rd.rvalid <= 1'b0;

			if (fill) begin
				line_valid[wr_index] <= 1'b1;
				wr.bvalid <= 1'b1;
			end else if (wr.bready) begin
				wr.bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (rd.arvalid && rd.arready) begin
			if (rd_hit) begin
				rd.rdata <= line_data[rd_index];
				rd.rresp <= okay;
			end else begin
				rd.rdata <= '0;
				rd.rresp <= decerr; // miss
			end
		end
		if (fill) begin
			line_tag[wr_index] <= wr.awaddr[addr_width-1:icache_index_bits+2];
			line_data[wr_index] <= wr.wdata;
		end
	end

	assign wr.bresp = okay;

	assert property (@(posedge clock) disable iff (reset) wr.wvalid |-> wr.awvalid);

endmodule

`default_nettype wire

// File: hdl/read_xbar.sv
`timescale 1ns/1ps
`default_nettype none

module read_xbar (
	input wire clock,
	input wire reset,

	input wire [fabric_pkg::addr_width-1:0] ifu_araddr,
	input wire ifu_arvalid,
	output logic ifu_arready,
	output logic [fabric_pkg::data_width-1:0] ifu_rdata,
	output fabric_pkg::resp_t ifu_rresp,
	output logic ifu_rvalid,
	input wire ifu_rready,

	input wire [fabric_pkg::addr_width-1:0] lsu_araddr,
	input wire lsu_arvalid,
	output logic lsu_arready,
	output logic [fabric_pkg::data_width-1:0] lsu_rdata,
	output fabric_pkg::resp_t lsu_rresp,
	output logic lsu_rvalid,
	input wire lsu_rready,

	output logic [fabric_pkg::addr_width-1:0] mem_araddr,
	output logic mem_arvalid,
	input wire mem_arready,
	input wire [fabric_pkg::data_width-1:0] mem_rdata,
	input wire fabric_pkg::resp_t mem_rresp,
	input wire mem_rvalid,
	output logic mem_rready,

	axi_read_if.requester cache_rd,
	axi_write_if.requester cache_wr,
	axi_read_if.requester clint_rd
);
	import fabric_pkg::*;

	function automatic logic in_range(input logic [addr_width-1:0] addr,
			input logic [addr_width-1:0] base, input logic [addr_width-1:0] limit);
		return (addr >= base) && (addr <= limit);
	endfunction

	xbar_state_t state;
	logic [addr_width-1:0] addr_q;
	logic cacheable_q;
	logic to_clint_q;
	logic [data_width-1:0] reply_data;
	resp_t reply_resp;
	logic ifu_cacheable;
	logic lsu_to_clint;
	logic ifu_accept;
	logic lsu_accept;
	logic mem_done;

	assign ifu_cacheable = in_range(ifu_araddr, flash_base, flash_limit) ||
		in_range(ifu_araddr, psram_base, psram_limit) ||
		in_range(ifu_araddr, sdram_base, sdram_limit);
	assign lsu_to_clint = in_range(lsu_araddr, clint_base, clint_limit);

	assign ifu_accept = ifu_arvalid && ifu_arready;
	assign lsu_accept = lsu_arvalid && lsu_arready;
	assign mem_done = mem_rvalid && mem_rready;

	assign mem_araddr = addr_q;
	assign mem_rready = (state == ifu_mem_read) || (state == lsu_read && !to_clint_q);

	assign cache_rd.araddr = addr_q;
	assign cache_rd.rready = (state == ifu_cache_lookup);
	assign clint_rd.araddr = addr_q;
	assign clint_rd.rready = (state == lsu_read) && to_clint_q;
	assign cache_wr.awaddr = addr_q;
	assign cache_wr.wdata = reply_data; // the word just read from memory
	assign cache_wr.bready = (state == cache_fill);

	// one reply register serves both ports since only one transaction is ever open
	assign ifu_rdata = reply_data;
	assign ifu_rresp = reply_resp;
	assign lsu_rdata = reply_data;
	assign lsu_rresp = reply_resp;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= idle;
			ifu_arready <= 1'b0;
			lsu_arready <= 1'b0;
			ifu_rvalid <= 1'b0;
			lsu_rvalid <= 1'b0;
			mem_arvalid <= 1'b0;
			cache_rd.arvalid <= 1'b0;
			clint_rd.arvalid <= 1'b0;
			cache_wr.awvalid <= 1'b0;
			cache_wr.wvalid <= 1'b0;
		end else begin
			ifu_arready <= 1'b0; // arready is a single cycle pulse
			lsu_arready <= 1'b0;
			if (mem_arvalid && mem_arready) mem_arvalid <= 1'b0;
			if (cache_rd.arvalid && cache_rd.arready) cache_rd.arvalid <= 1'b0;
			if (clint_rd.arvalid && clint_rd.arready) clint_rd.arvalid <= 1'b0;
			if (cache_wr.awvalid && cache_wr.awready) cache_wr.awvalid <= 1'b0;
			if (cache_wr.wvalid && cache_wr.wready) cache_wr.wvalid <= 1'b0;

			case (state)
				idle: begin
					if (ifu_accept) begin
						if (ifu_cacheable) begin
							cache_rd.arvalid <= 1'b1;
							state <= ifu_cache_lookup;
						end else begin
							mem_arvalid <= 1'b1;
							state <= ifu_mem_read;
						end
					end else if (lsu_accept) begin
						clint_rd.arvalid <= lsu_to_clint;
						mem_arvalid <= !lsu_to_clint;
						state <= lsu_read;
					end else if (!ifu_arready && !lsu_arready) begin
						if (ifu_arvalid) ifu_arready <= 1'b1; // fetch wins a tie
						else if (lsu_arvalid) lsu_arready <= 1'b1;
					end
				end
				ifu_cache_lookup: begin
					if (cache_rd.rvalid && cache_rd.rready) begin
						if (cache_rd.rresp == decerr) begin
							mem_arvalid <= 1'b1;
							state <= ifu_mem_read;
						end else begin
							ifu_rvalid <= 1'b1;
							state <= ifu_reply;
						end
					end
				end
				ifu_mem_read: begin
					if (mem_done) begin
						if (cacheable_q && !mem_rresp[1]) begin
							cache_wr.awvalid <= 1'b1;
							cache_wr.wvalid <= 1'b1;
							state <= cache_fill;
						end else begin
							ifu_rvalid <= 1'b1;
							state <= ifu_reply;
						end
					end
				end
				cache_fill: begin
					if (cache_wr.bvalid && cache_wr.bready) begin
						ifu_rvalid <= 1'b1;
						state <= ifu_reply;
					end
				end
				ifu_reply: begin
					if (ifu_rready) begin
						ifu_rvalid <= 1'b0;
						state <= idle;
					end
				end
				lsu_read: begin
					if (mem_done || (clint_rd.rvalid && clint_rd.rready)) begin
						lsu_rvalid <= 1'b1;
						state <= lsu_reply;
					end
				end
				lsu_reply: begin
					if (lsu_rready) begin
						lsu_rvalid <= 1'b0;
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (ifu_accept) begin
			addr_q <= ifu_araddr;
			cacheable_q <= ifu_cacheable;
			to_clint_q <= 1'b0;
		end else if (lsu_accept) begin
			addr_q <= lsu_araddr;
			cacheable_q <= 1'b0;
			to_clint_q <= lsu_to_clint;
		end
		if (cache_rd.rvalid && cache_rd.rready) begin
			reply_data <= cache_rd.rdata;
			reply_resp <= cache_rd.rresp;
		end else if (mem_done) begin
			reply_data <= mem_rdata;
			reply_resp <= mem_rresp;
		end else if (clint_rd.rvalid && clint_rd.rready) begin
			reply_data <= clint_rd.rdata;
			reply_resp <= clint_rd.rresp;
		end
	end

	// only one target is ever addressed at a time
	assert property (@(posedge clock) disable iff (reset)
		$onehot0({mem_arvalid, cache_rd.arvalid, clint_rd.arvalid}));

	assert property (@(posedge clock) disable iff (reset)
		ifu_rvalid && !ifu_rready |=> ifu_rvalid && $stable(ifu_rdata) && $stable(ifu_rresp));

endmodule

`default_nettype wire

// File: verification/tb_fetch_fabric.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_fabric;
	import fabric_pkg::*;

	localparam int watchdog_ns = 20000; // far longer than all tests together need

	logic clock;
	logic reset;
	logic [31:0] ifu_araddr, ifu_rdata, lsu_araddr, lsu_rdata, mem_araddr, mem_rdata;
	logic ifu_arvalid, ifu_arready, ifu_rvalid, ifu_rready;
	logic lsu_arvalid, lsu_arready, lsu_rvalid, lsu_rready;
	logic mem_arvalid, mem_arready, mem_rvalid, mem_rready;
	resp_t ifu_rresp, lsu_rresp, mem_rresp;

	int errors = 0;
	int mem_reads = 0;
	int ifu_accepts = 0;
	int lsu_accepts = 0;
	logic [31:0] last_mem_addr;
	time ifu_accept_time, lsu_accept_time, ifu_reply_time;
	logic [31:0] lfsr_state = 32'hac9d_2804;

	fetch_fabric DUT (.*);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // taps 32, 22, 2, 1
	endfunction

	task automatic random_bits(input int n, output int value);
		value = 0;
		repeat (n) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = (value << 1) | lfsr_state[0];
		end
	endtask

	// what the external memory returns for a read
	function automatic logic [31:0] model_data(input logic [31:0] addr);
		return addr ^ 32'h5a5a_0000;
	endfunction

	function automatic resp_t model_resp(input logic [31:0] addr);
		return (addr >= 32'hf000_0000) ? slverr : okay;
	endfunction

	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("FAIL %s: expected %h, actual %h", name, expected, actual);
		errors++;
	endtask

	task automatic report_problem(input string text);
		$display("ERROR %s", text);
		errors++;
	endtask

	initial begin : mem_responder
		int delay;
		logic [31:0] req_addr;
		mem_arready = 1'b0;
		mem_rvalid = 1'b0;
		mem_rdata = '0;
		mem_rresp = okay;
		forever begin
			next_cycle();
			if (mem_arvalid === 1'b1) begin
				random_bits(2, delay);
				repeat (delay) next_cycle();
				req_addr = mem_araddr;
				mem_arready = 1'b1;
				next_cycle(); // address handshake on this edge
				mem_arready = 1'b0;
				mem_reads++;
				last_mem_addr = req_addr;
				random_bits(2, delay);
				repeat (delay) next_cycle();
				mem_rdata = model_data(req_addr);
				mem_rresp = model_resp(req_addr);
				mem_rvalid = 1'b1;
				while (!mem_rready) next_cycle();
				next_cycle();
				mem_rvalid = 1'b0;
			end
		end
	end

	// handshakes complete on the next rising edge and are sampled here where all is stable
	always @(negedge clock) begin
		if (ifu_arvalid && ifu_arready) begin
			ifu_accepts++;
			ifu_accept_time = $time;
		end
		if (lsu_arvalid && lsu_arready) begin
			lsu_accepts++;
			lsu_accept_time = $time;
		end
		if (ifu_rvalid && ifu_rready) ifu_reply_time = $time;
	end

	task automatic request(input bit from_lsu, input logic [31:0] addr);
		if (from_lsu) begin
			lsu_araddr = addr;
			lsu_arvalid = 1'b1;
			while (!lsu_arready) next_cycle();
			next_cycle();
			lsu_arvalid = 1'b0;
		end else begin
			ifu_araddr = addr;
			ifu_arvalid = 1'b1;
			while (!ifu_arready) next_cycle();
			next_cycle();
			ifu_arvalid = 1'b0;
		end
	endtask

	task automatic take_reply(input bit from_lsu, output logic [31:0] data,
			output logic [1:0] resp);
		if (from_lsu) begin
			while (!lsu_rvalid) next_cycle();
			data = lsu_rdata;
			resp = lsu_rresp;
			lsu_rready = 1'b1;
			next_cycle();
			lsu_rready = 1'b0;
		end else begin
			while (!ifu_rvalid) next_cycle();
			data = ifu_rdata;
			resp = ifu_rresp;
			ifu_rready = 1'b1;
			next_cycle();
			ifu_rready = 1'b0;
		end
	endtask

	task automatic bus_read(input bit from_lsu, input logic [31:0] addr,
			output logic [31:0] data, output logic [1:0] resp);
		request(from_lsu, addr);
		take_reply(from_lsu, data, resp);
	endtask

	task automatic reset_state();
		logic [4:0] flags;
		flags = {ifu_arready, lsu_arready, ifu_rvalid, lsu_rvalid, mem_arvalid};
		if (flags !== 5'b0) report_mismatch("reset_state", 32'd0, {27'd0, flags});
	endtask

	task automatic uncacheable_fetch();
		int reads;
		logic [31:0] data;
		logic [1:0] resp;
		reads = mem_reads;
		bus_read(1'b0, 32'h2000_0010, data, resp);
		if (mem_reads != reads + 1)
			report_mismatch("uncacheable_fetch reads", reads + 1, mem_reads);
		if (last_mem_addr !== 32'h2000_0010)
			report_mismatch("uncacheable_fetch address", 32'h2000_0010, last_mem_addr);
		if (data !== model_data(32'h2000_0010))
			report_mismatch("uncacheable_fetch data", model_data(32'h2000_0010), data);
		if (resp !== okay) report_mismatch("uncacheable_fetch resp", okay, resp);
		bus_read(1'b0, 32'hf000_0000, data, resp);
		if (resp !== slverr) report_mismatch("uncacheable_fetch error resp", slverr, resp);
	endtask

	task automatic miss_then_hit();
		logic [31:0] first;
		logic [31:0] conflict;
		logic [31:0] data;
		logic [1:0] resp;
		int reads;
		first = 32'h3000_0040;
		conflict = first + icache_lines * 4; // same index with the next tag
		reads = mem_reads;
		bus_read(1'b0, first, data, resp);
		if (mem_reads != reads + 1)
			report_mismatch("miss_then_hit miss reads", reads + 1, mem_reads);
		if (data !== model_data(first))
			report_mismatch("miss_then_hit miss data", model_data(first), data);
		reads = mem_reads;
		bus_read(1'b0, first, data, resp);
		if (mem_reads != reads) report_mismatch("miss_then_hit hit reads", reads, mem_reads);
		if (data !== model_data(first))
			report_mismatch("miss_then_hit hit data", model_data(first), data);
		if (resp !== okay) report_mismatch("miss_then_hit hit resp", okay, resp);
		bus_read(1'b0, conflict, data, resp);
		if (mem_reads != reads + 1)
			report_mismatch("miss_then_hit conflict reads", reads + 1, mem_reads);
		if (data !== model_data(conflict))
			report_mismatch("miss_then_hit conflict data", model_data(conflict), data);
		reads = mem_reads;
		bus_read(1'b0, first, data, resp);
		if (mem_reads != reads + 1)
			report_mismatch("miss_then_hit evicted reads", reads + 1, mem_reads);
		if (data !== model_data(first))
			report_mismatch("miss_then_hit evicted data", model_data(first), data);
	endtask

	task automatic lsu_routing();
		logic [31:0] data;
		logic [31:0] time_lo;
		logic [1:0] resp;
		int reads;
		reads = mem_reads;
		bus_read(1'b1, 32'h8000_0100, data, resp);
		if (mem_reads != reads + 1)
			report_mismatch("lsu_routing memory reads", reads + 1, mem_reads);
		if (data !== model_data(32'h8000_0100))
			report_mismatch("lsu_routing memory data", model_data(32'h8000_0100), data);
		reads = mem_reads;
		bus_read(1'b1, 32'h0200_0000, time_lo, resp);
		bus_read(1'b1, 32'h0200_0000, data, resp);
		if (mem_reads != reads) report_mismatch("lsu_routing clint reads", reads, mem_reads);
		if (!(data > time_lo))
			report_problem($sformatf("lsu_routing: mtime did not advance (%0d then %0d)",
				time_lo, data));
		bus_read(1'b1, 32'h0200_0004, data, resp);
		if (data !== 32'd0) report_mismatch("lsu_routing mtime high", 32'd0, data);
		if (resp !== okay) report_mismatch("lsu_routing mtime high resp", okay, resp);
		bus_read(1'b1, 32'h0200_0008, data, resp);
		if (resp !== slverr) report_mismatch("lsu_routing bad offset resp", slverr, resp);
	endtask

	task automatic arbitration();
		logic [31:0] ifu_data, lsu_data;
		logic [1:0] ifu_resp, lsu_resp;
		fork
			bus_read(1'b0, 32'h2000_0020, ifu_data, ifu_resp);
			bus_read(1'b1, 32'h0200_0000, lsu_data, lsu_resp);
		join
		if (!(ifu_accept_time < lsu_accept_time))
			report_problem("arbitration: the LSU request was accepted before the IFU request");
		if (!(lsu_accept_time > ifu_reply_time))
			report_problem("arbitration: the LSU was accepted before the IFU reply was taken");
		if (ifu_data !== model_data(32'h2000_0020))
			report_mismatch("arbitration ifu data", model_data(32'h2000_0020), ifu_data);
		if (lsu_resp !== okay) report_mismatch("arbitration lsu resp", okay, lsu_resp);
	endtask

	task automatic back_pressure();
		logic [31:0] held_data, data;
		logic [1:0] held_resp, resp;
		int accepts;
		request(1'b0, 32'h2000_0030);
		while (!ifu_rvalid) next_cycle();
		held_data = ifu_rdata;
		held_resp = ifu_rresp;
		lsu_araddr = 32'h0200_0000; // a competing load during the stall
		lsu_arvalid = 1'b1;
		accepts = ifu_accepts + lsu_accepts;
		repeat (5) begin
			next_cycle();
			if (ifu_rvalid !== 1'b1)
				report_problem("back_pressure: ifu_rvalid dropped before rready");
			if (ifu_rdata !== held_data)
				report_mismatch("back_pressure data", held_data, ifu_rdata);
			if (ifu_rresp !== held_resp)
				report_mismatch("back_pressure resp", held_resp, ifu_rresp);
		end
		if (ifu_accepts + lsu_accepts != accepts)
			report_problem("back_pressure: a request was accepted while a reply was stalled");
		take_reply(1'b0, data, resp);
		if (data !== model_data(32'h2000_0030))
			report_mismatch("back_pressure final data", model_data(32'h2000_0030), data);
		if (resp !== okay) report_mismatch("back_pressure final resp", okay, resp);
		bus_read(1'b1, 32'h0200_0000, data, resp);
		if (resp !== okay) report_mismatch("back_pressure lsu resp", okay, resp);
	endtask

	initial begin
		reset = 1'b1;
		ifu_araddr = '0;
		ifu_arvalid = 1'b0;
		ifu_rready = 1'b0;
		lsu_araddr = '0;
		lsu_arvalid = 1'b0;
		lsu_rready = 1'b0;
		repeat (8) @(posedge clock);
		#1 reset = 1'b0;
		reset_state();
		uncacheable_fetch();
		miss_then_hit();
		lsu_routing();
		arbitration();
		back_pressure();
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		#watchdog_ns;
		$display("timeout: the tests did not finish within %0d ns, errors: %0d",
			watchdog_ns, errors);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
hdl/fabric_pkg.sv
hdl/axi_lite_if.sv
hdl/read_xbar.sv
hdl/icache.sv
hdl/clint.sv
hdl/fetch_fabric.sv
verification/tb_fetch_fabric.sv
